// ==== compile.f ====
source/sampler_pkg.sv
source/abr_piso_multi.sv
source/sample_filter.sv
source/coeff_serializer.sv
source/sampler_top.sv
tests/tb_sampler_top.sv

// ==== Bender.yml ====
package:
  name: sampler

sources:
  - source/sampler_pkg.sv
  - source/abr_piso_multi.sv
  - source/sample_filter.sv
  - source/coeff_serializer.sv
  - source/sampler_top.sv
  - target: test
    files:
      - tests/tb_sampler_top.sv

// ==== tests/tb_sampler_top.sv ====
/*
 * Testbench for the coefficient sampler: random squeeze blocks in all
 * three modes, a bit-level reference model and assertion-based checks
 */
`timescale 1ns/1ps

module tb_sampler_top;

  import sampler_pkg::*;

  localparam int N_BLOCKS     = 24;
  localparam int TOTAL_BLOCKS = 130;

  logic        clk;
  logic        rst_b;
  logic        zeroize_i;
  mode_e       mode_i;
  logic        block_valid_i;
  logic        block_hold_o;
  logic [63:0] block_data_i;
  logic        coef_valid_o;
  logic        coef_hold_i;
  logic [11:0] coef_o;

  // Expected coefficients and the bits not yet cut into words
  int          exp_q[$];
  bit          model_bits[$];
  logic [11:0] exp_head;
  int          exp_cnt;
  int          errors;
  int          n_coef;
  bit          idle_expected;
  bit          hold_seen;
  bit          hold_rand;
  bit          coef_taken;
  string       test_name;

  sampler_top i_sampler_top (
    .clk           (clk),
    .rst_b         (rst_b),
    .zeroize_i     (zeroize_i),
    .mode_i        (mode_i),
    .block_valid_i (block_valid_i),
    .block_hold_o  (block_hold_o),
    .block_data_i  (block_data_i),
    .coef_valid_o  (coef_valid_o),
    .coef_hold_i   (coef_hold_i),
    .coef_o        (coef_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic void refresh_head();
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt != 0) ? 12'(exp_q[0]) : '0;
  endfunction

  // Bits join LSB first, words are cut at the mode's output rate
  task automatic model_block(input logic [63:0] data);
    int          in_rate;
    int          out_rate;
    int          val;
    logic [23:0] word;
    in_rate  = (mode_i == MODE_UNIFORM_B) ? 48 : 64;
    out_rate = (mode_i == MODE_ETA) ? 16 : 24;
    for (int i = 0; i < in_rate; i++)
      model_bits.push_back(data[i]);
    while (model_bits.size() >= out_rate) begin
      word = '0;
      for (int i = 0; i < out_rate; i++)
        word[i] = model_bits.pop_front();
      if (mode_i == MODE_ETA) begin
        for (int i = 0; i < 4; i++) begin
          val = int'(word[4*i +: 4]);
          if (val < 15)
            exp_q.push_back((3329 + 2 - val % 5) % 3329);
        end
      end else begin
        for (int i = 0; i < 2; i++) begin
          val = int'(word[12*i +: 12]);
          if (val < 3329)
            exp_q.push_back(val);
        end
      end
    end
    refresh_head();
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #10;
    coef_hold_i = hold_rand ? 1'($urandom) : 1'b0;
  endtask

  task automatic send_block(input logic [63:0] data);
    bit accepted;
    block_valid_i = 1'b1;
    block_data_i  = data;
    idle_expected = 1'b0;
    model_block(data);
    do begin
      @(negedge clk);
      accepted = !block_hold_o;
      next_cycle();
    end while (!accepted);
    block_valid_i = 1'b0;
  endtask

  task automatic apply_zeroize(input mode_e new_mode);
    zeroize_i = 1'b1;
    next_cycle();
    zeroize_i = 1'b0;
    mode_i    = new_mode;
    model_bits.delete();
    exp_q.delete();
    refresh_head();
    idle_expected = 1'b1;
  endtask

  task automatic run_stream(input string name, input mode_e mode, input bit rand_hold);
    apply_zeroize(mode);
    test_name = name;
    hold_rand = rand_hold;
    // Nibbles 3 and 4 map to Q-1 and Q-2
    if (mode == MODE_ETA)
      send_block(64'h4343_4343_4343_4343);
    repeat (N_BLOCKS) send_block({$urandom, $urandom});
    while (exp_cnt != 0)
      next_cycle();
    repeat (4) next_cycle();
    hold_rand = 1'b0;
  endtask

  // Handshake seen at the falling edge, retired at the next rising edge
  always @(negedge clk) begin
    coef_taken = rst_b && coef_valid_o && !coef_hold_i;
    if (block_hold_o)
      hold_seen = 1'b1;
  end

  always @(posedge clk) begin
    if (coef_taken && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      n_coef++;
      refresh_head();
    end
  end

  a_coef_match: assert property (
    @(posedge clk) disable iff (!rst_b)
    (coef_valid_o && !coef_hold_i && exp_cnt != 0) |-> (coef_o == exp_head)
  ) else begin
    errors++;
    $display("Fail %s: expected %0d, actual %0d", test_name, $sampled(exp_head),
             $sampled(coef_o));
  end

  a_no_extra: assert property (
    @(posedge clk) disable iff (!rst_b)
    (coef_valid_o && !coef_hold_i) |-> (exp_cnt != 0)
  ) else begin
    errors++;
    $display("Coefficient %0d emitted with none expected in %s", $sampled(coef_o), test_name);
  end

  a_idle: assert property (
    @(posedge clk) disable iff (!rst_b)
    idle_expected |-> (!coef_valid_o && !block_hold_o)
  ) else begin
    errors++;
    $display("Outputs not idle after reset or zeroize in %s", test_name);
  end

  initial begin
    repeat (TOTAL_BLOCKS * 40 + 100) @(posedge clk);
    $display("Timeout: pipeline stalled in %s", test_name);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h19f0_7f58));
    rst_b = 1'b0;
    zeroize_i = 1'b0;
    mode_i = MODE_UNIFORM_A;
    block_valid_i = 1'b0;
    block_data_i = '0;
    coef_hold_i = 1'b0;
    errors = 0;
    n_coef = 0;
    idle_expected = 1'b1;
    test_name = "reset";
    refresh_head();
    repeat (8) next_cycle();
    rst_b = 1'b1;
    repeat (4) next_cycle();
    run_stream("uniform_a", MODE_UNIFORM_A, 1'b0);
    run_stream("uniform_b", MODE_UNIFORM_B, 1'b0);
    run_stream("eta", MODE_ETA, 1'b0);
    hold_seen = 1'b0;
    run_stream("backpressure", MODE_UNIFORM_A, 1'b1);
    a_hold_seen: assert (hold_seen) else begin
      errors++;
      $display("block_hold_o never rose under back-pressure");
    end
    // Partial stream left in flight, then wiped by the next zeroize
    hold_rand = 1'b1;
    repeat (8) send_block({$urandom, $urandom});
    run_stream("zeroize_mode_change", MODE_ETA, 1'b1);
    $display("Coefficients checked: %0d, errors: %0d", n_coef, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== source/sampler_top.sv ====
/*
 * Coefficient sampler top: PISO, rejection filter and serializer
 * chained with valid/hold handshakes
 */
`timescale 1ns/1ps

module sampler_top (
  input  logic                            clk,
  input  logic                            rst_b,
  input  logic                            zeroize_i,
  input  sampler_pkg::mode_e              mode_i,
  input  logic                            block_valid_i,
  output logic                            block_hold_o,
  input  logic [sampler_pkg::BLOCK_W-1:0] block_data_i,
  output logic                            coef_valid_o,
  input  logic                            coef_hold_i,
  output logic [sampler_pkg::COEF_W-1:0]  coef_o
);

  import sampler_pkg::*;

  logic         word_valid;
  logic         word_hold;
  sample_word_u word_data;
  logic         group_valid;
  logic         group_hold;
  coef_group_t  group_data;

  abr_piso_multi i_piso (
    .clk       (clk),
    .rst_b     (rst_b),
    .zeroize_i (zeroize_i),
    .mode_i    (mode_i),
    .valid_i   (block_valid_i),
    .hold_o    (block_hold_o),
    .data_i    (block_data_i),
    .valid_o   (word_valid),
    .hold_i    (word_hold),
    .data_o    (word_data)
  );

  sample_filter i_filter (
    .clk           (clk),
    .rst_b         (rst_b),
    .zeroize_i     (zeroize_i),
    .mode_i        (mode_i),
    .word_valid_i  (word_valid),
    .word_hold_o   (word_hold),
    .word_i        (word_data),
    .group_valid_o (group_valid),
    .group_hold_i  (group_hold),
    .group_o       (group_data)
  );

  coeff_serializer i_serializer (
    .clk           (clk),
    .rst_b         (rst_b),
    .zeroize_i     (zeroize_i),
    .group_valid_i (group_valid),
    .group_hold_o  (group_hold),
    .group_i       (group_data),
    .coef_valid_o  (coef_valid_o),
    .coef_hold_i   (coef_hold_i),
    .coef_o        (coef_o)
  );

endmodule

// ==== source/coeff_serializer.sv ====
/*
 * Coefficient serializer: holds one accepted group and emits its
 * coefficients one per transfer in index order
 */
`timescale 1ns/1ps

module coeff_serializer (
  input  logic                            clk,
  input  logic                            rst_b,
  input  logic                            zeroize_i,
  input  logic                            group_valid_i,
  output logic                            group_hold_o,
  input  sampler_pkg::coef_group_t        group_i,
  output logic                            coef_valid_o,
  input  logic                            coef_hold_i,
  output logic [sampler_pkg::COEF_W-1:0]  coef_o
);

  import sampler_pkg::*;

  coef_group_t      group_q;
  logic [CNT_W-2:0] idx_q;
  logic             valid_q;
  logic             last;
  logic             coef_take;
  logic             group_take;

  assign last      = (CNT_W'(idx_q) + CNT_W'(1)) == group_q.count;
  assign coef_take = valid_q & ~coef_hold_i;

  // Next group may enter while the last coefficient goes out
  assign group_hold_o = valid_q & ~(coef_take & last);
  assign group_take   = group_valid_i & ~group_hold_o;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      valid_q <= 1'b0;
      idx_q   <= '0;
    end else if (zeroize_i) begin
      valid_q <= 1'b0;
      idx_q   <= '0;
    end else if (group_take) begin
      valid_q <= 1'b1;
      idx_q   <= '0;
    end else if (coef_take) begin
      if (last) begin
        valid_q <= 1'b0;
        idx_q   <= '0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (group_take) begin
      group_q <= group_i;
    end
  end

  assign coef_valid_o = valid_q;
  assign coef_o       = group_q.coef[idx_q];

  // Covers both decode paths of the filter and the ETA lift
  a_coef_below_q: assert property (
    @(posedge clk) disable iff (!rst_b)
    coef_valid_o |-> (coef_o < COEF_W'(Q))
  ) else $error("Emitted coefficient %0d is not below Q", coef_o);

endmodule

// ==== source/sample_filter.sv ====
/*
 * Rejection filter: decodes one word per the mode, keeps the valid
 * candidates and registers them as a compacted group
 */
`timescale 1ns/1ps

module sample_filter (
  input  logic                      clk,
  input  logic                      rst_b,
  input  logic                      zeroize_i,
  input  sampler_pkg::mode_e        mode_i,
  input  logic                      word_valid_i,
  output logic                      word_hold_o,
  input  sampler_pkg::sample_word_u word_i,
  output logic                      group_valid_o,
  input  logic                      group_hold_i,
  output sampler_pkg::coef_group_t  group_o
);

  import sampler_pkg::*;

  logic [MAX_CAND-1:0]             keep;
  logic [MAX_CAND-1:0][COEF_W-1:0] cand_val;
  logic [CNT_W-1:0]                kept_cnt;
  coef_group_t                     group_d;
  coef_group_t                     group_q;
  logic                            group_valid_q;
  logic                            word_take;

  // Centred value ETA_VALUE - (nib mod 5), lifted into [0, Q)
  function automatic logic [COEF_W-1:0] eta_map(input logic [NIB_W-1:0] nib);
    logic [2:0] r;
    r = 3'(nib % 4'd5);
    if (r <= ETA_VALUE) begin
      eta_map = COEF_W'(ETA_VALUE) - COEF_W'(r);
    end else begin
      eta_map = COEF_W'(Q + ETA_VALUE) - COEF_W'(r);
    end
  endfunction

  always_comb begin
    keep     = '0;
    cand_val = '0;
    if (mode_i == MODE_ETA) begin
      for (int i = 0; i < MAX_CAND; i++) begin
        keep[i]     = word_i.eta.nib[i] < ETA_BOUND;
        cand_val[i] = eta_map(word_i.eta.nib[i]);
      end
    end else begin
      for (int i = 0; i < WORD_W / COEF_W; i++) begin
        keep[i]     = word_i.uni.cand[i] < Q;
        cand_val[i] = word_i.uni.cand[i];
      end
    end
  end

  // Compact kept values towards index 0, order preserved
  always_comb begin
    group_d  = '0;
    kept_cnt = '0;
    for (int i = 0; i < MAX_CAND; i++) begin
      if (keep[i]) begin
        group_d.coef[kept_cnt[CNT_W-2:0]] = cand_val[i];
        kept_cnt = kept_cnt + CNT_W'(1);
      end
    end
    group_d.count = kept_cnt;
  end

  // Accept when empty or when the held group leaves this cycle
  assign word_hold_o = group_valid_q & group_hold_i;
  assign word_take   = word_valid_i & ~word_hold_o;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      group_valid_q <= 1'b0;
    end else if (zeroize_i) begin
      group_valid_q <= 1'b0;
    end else if (word_take) begin
      // A fully rejected word is consumed without output
      group_valid_q <= kept_cnt != '0;
    end else if (!group_hold_i) begin
      group_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (word_take && kept_cnt != '0) begin
      group_q <= group_d;
    end
  end

  assign group_valid_o = group_valid_q;
  assign group_o       = group_q;

  a_group_count: assert property (
    @(posedge clk) disable iff (!rst_b)
    group_valid_q |-> (group_q.count >= CNT_W'(1) && group_q.count <= CNT_W'(MAX_CAND))
  ) else $error("Registered group has count %0d", group_q.count);

endmodule

// ==== source/abr_piso_multi.sv ====
/*
 * Multi-mode PISO: appends squeeze blocks at the mode's input rate
 * and hands out words at the mode's output rate, LSB first
 */
`timescale 1ns/1ps

module abr_piso_multi (
  input  logic                              clk,
  input  logic                              rst_b,
  input  logic                              zeroize_i,
  input  sampler_pkg::mode_e                mode_i,
  input  logic                              valid_i,
  output logic                              hold_o,
  input  logic [sampler_pkg::BLOCK_W-1:0]   data_i,
  output logic                              valid_o,
  input  logic                              hold_i,
  output logic [sampler_pkg::WORD_W-1:0]    data_o
);

  import sampler_pkg::*;

  logic [BUFFER_W-1:0] buffer_q;
  logic [BUFFER_W-1:0] buffer_d;
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    wr_ptr_d;
  logic [PTR_W-1:0]    in_rate;
  logic [PTR_W-1:0]    out_rate;
  logic [BUFFER_W-1:0] wdata;
  logic [BUFFER_W-1:0] wdata_mask;
  logic                buf_wr;
  logic                buf_rd;

  always_comb begin
    in_rate  = PTR_W'(IN_RATES[mode_i]);
    out_rate = PTR_W'(OUT_RATES[mode_i]);
  end

  // Room check counts the word leaving in this same cycle
  always_comb begin
    if (buf_rd) begin
      hold_o = wr_ptr_q > (PTR_W'(BUFFER_W) - in_rate + out_rate);
    end else begin
      hold_o = wr_ptr_q > (PTR_W'(BUFFER_W) - in_rate);
    end
  end

  assign valid_o = wr_ptr_q >= out_rate;
  assign data_o  = buffer_q[WORD_W-1:0];

  assign buf_wr = valid_i & ~hold_o;
  assign buf_rd = valid_o & ~hold_i;

  // Drop the block bits above the input rate (UNIFORM_B uses 48 of 64)
  always_comb begin
    wdata_mask = {BUFFER_W{1'b1}} >> (PTR_W'(BUFFER_W) - in_rate);
    wdata      = BUFFER_W'(data_i) & wdata_mask;
  end

  always_comb begin
    case ({buf_rd, buf_wr})
      2'b01: begin
        wr_ptr_d = wr_ptr_q + in_rate;
        buffer_d = buffer_q | (wdata << wr_ptr_q);
      end
      2'b10: begin
        wr_ptr_d = wr_ptr_q - out_rate;
        buffer_d = buffer_q >> out_rate;
      end
      2'b11: begin
        // New bits land just above what remains after the shift
        wr_ptr_d = wr_ptr_q + (in_rate - out_rate);
        buffer_d = (buffer_q >> out_rate) | (wdata << (wr_ptr_q - out_rate));
      end
      default: begin
        wr_ptr_d = wr_ptr_q;
        buffer_d = buffer_q;
      end
    endcase
  end

  // Bits above the pointer must stay zero since writes are OR-merged
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      buffer_q <= '0;
      wr_ptr_q <= '0;
    end else if (zeroize_i) begin
      buffer_q <= '0;
      wr_ptr_q <= '0;
    end else if (buf_wr || buf_rd) begin
      buffer_q <= buffer_d;
      wr_ptr_q <= wr_ptr_d;
    end
  end

  a_ptr_in_range: assert property (
    @(posedge clk) disable iff (!rst_b)
    wr_ptr_q <= PTR_W'(BUFFER_W)
  ) else $error("PISO write pointer beyond buffer width: %0d", wr_ptr_q);

  // Rates are taken from the live mode, so buffered bits would be cut wrongly
  a_mode_stable: assert property (
    @(posedge clk) disable iff (!rst_b || zeroize_i)
    (wr_ptr_q != '0) |-> $stable(mode_i)
  ) else $error("Mode changed while the PISO holds %0d bits", wr_ptr_q);

endmodule

// ==== source/sampler_pkg.sv ====
/*
 * Coefficient sampler shared definitions: widths, mode encoding,
 * the decoded word view and the inter-stage group struct
 */
package sampler_pkg;

  localparam int NUM_MODES = 3;

  typedef enum logic [1:0] {
    MODE_UNIFORM_A = 2'd0,
    MODE_UNIFORM_B = 2'd1,
    MODE_ETA       = 2'd2
  } mode_e;

  // PISO geometry
  localparam int BLOCK_W  = 64;
  localparam int WORD_W   = 24;
  localparam int BUFFER_W = 88;
  localparam int PTR_W    = 7;

  // Per-mode rates, indexed by mode_e
  localparam int IN_RATES  [NUM_MODES] = '{64, 48, 64};
  localparam int OUT_RATES [NUM_MODES] = '{24, 24, 16};

  // Coefficient arithmetic
  localparam int COEF_W    = 12;
  localparam int Q         = 3329;
  localparam int NIB_W     = 4;
  localparam int ETA_BOUND = 15;
  localparam int ETA_VALUE = 2;

  localparam int MAX_CAND = 4;
  localparam int CNT_W    = 3;

  // Uniform view, candidate 0 sits in the low bits
  typedef struct packed {
    logic [WORD_W/COEF_W-1:0][COEF_W-1:0] cand;
  } uni_view_t;

  // ETA view, only nibbles 0 to 3 are used
  typedef struct packed {
    logic [WORD_W/NIB_W-1:0][NIB_W-1:0] nib;
  } eta_view_t;

  typedef union packed {
    uni_view_t uni;
    eta_view_t eta;
  } sample_word_u;

  // Accepted coefficients packed towards index 0, count is 1 to MAX_CAND
  typedef struct packed {
    logic [MAX_CAND-1:0][COEF_W-1:0] coef;
    logic [CNT_W-1:0]                count;
  } coef_group_t;

endpackage
